// File: all.f
+incdir+.
mapper_pkg.sv
cluster_occupancy.sv
pe_selector.sv
cluster_arbiter.sv
map_controller.sv
task_mapper.sv
tb_task_mapper.sv

// File: cluster_arbiter.sv
// Active cluster register, reloaded at application end
// with the least busy cluster

`include "mapper_params.svh"

module cluster_arbiter
  import mapper_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_b,
  input  logic                            app_end,
  input  busy_cnt_t [`NUM_CLUSTERS-1:0]   busy_counts,
  output cluster_t                        active_cluster
);

  busy_cnt_t min_cnt;
  cluster_t  min_cl;

  // Minimum search, <= lets a later cluster take an equal count
  always_comb begin
    min_cnt = busy_counts[0];
    min_cl  = '0;
    for (int i = 1; i < `NUM_CLUSTERS; i++) begin
      if (busy_counts[i] <= min_cnt) begin
        min_cnt = busy_counts[i];
        min_cl  = cluster_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      active_cluster <= '0;
    end else if (app_end) begin
      active_cluster <= min_cl;
    end
  end

endmodule

// File: cluster_occupancy.sv
// Occupancy of one 4x4 cluster: busy bits, busy count, free mask
// and the idle-neighbor count of every PE

`include "mapper_params.svh"

module cluster_occupancy
  import mapper_pkg::*;
#(
  parameter local_idx_t CTRL_IDX = '0
) (
  input  logic            clk,
  input  logic            rst_b,
  input  logic            set_stb,
  input  local_idx_t      set_idx,
  input  logic            clr_stb,
  input  local_idx_t      clr_idx,
  output cluster_status_t status
);

  // Neighbor table, row p marks every PE at distance 1..NBR_DIST from p
  function automatic logic [`PE_PER_CL-1:0][`PE_PER_CL-1:0] build_nbr_tab();
    logic [`PE_PER_CL-1:0][`PE_PER_CL-1:0] tab;
    int dr;
    int dc;
    tab = '0;
    for (int p = 0; p < `PE_PER_CL; p++) begin
      for (int q = 0; q < `PE_PER_CL; q++) begin
        dr = p / `CL_DIM - q / `CL_DIM;
        dc = p % `CL_DIM - q % `CL_DIM;
        if (dr < 0) begin
          dr = -dr;
        end
        if (dc < 0) begin
          dc = -dc;
        end
        if ((dr + dc >= 1) && (dr + dc <= `NBR_DIST)) begin
          tab[p][q] = 1'b1;
        end
      end
    end
    return tab;
  endfunction

  localparam logic [`PE_PER_CL-1:0][`PE_PER_CL-1:0] NBR_TAB = build_nbr_tab();
  localparam logic [`PE_PER_CL-1:0] CTRL_MASK =
    {{(`PE_PER_CL-1){1'b0}}, 1'b1} << CTRL_IDX;

  logic [`PE_PER_CL-1:0] busy_q;
  logic [`PE_PER_CL-1:0] busy_next;
  logic [`PE_PER_CL-1:0] busy;
  logic [`PE_PER_CL-1:0] free_mask;
  busy_cnt_t             busy_count;
  nbr_cnt_t [`PE_PER_CL-1:0] idle_nbr;

  // ########################################
  // Occupancy register
  // ########################################
  always_comb begin
    busy_next = busy_q;
    // Set after clear, a release of the PE just picked leaves it busy
    if (clr_stb) begin
      busy_next[clr_idx] = 1'b0;
    end
    if (set_stb) begin
      busy_next[set_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

  // Controller PE never leaves the busy state
  assign busy      = busy_q | CTRL_MASK;
  assign free_mask = ~busy;

  // ########################################
  // Counts
  // ########################################
  always_comb begin
    busy_count = '0;
    for (int i = 0; i < `PE_PER_CL; i++) begin
      busy_count = busy_count + busy_cnt_t'(busy[i]);
    end
  end

  always_comb begin
    for (int p = 0; p < `PE_PER_CL; p++) begin
      idle_nbr[p] = '0;
      for (int q = 0; q < `PE_PER_CL; q++) begin
        idle_nbr[p] = idle_nbr[p] + nbr_cnt_t'(free_mask[q] & NBR_TAB[p][q]);
      end
    end
  end

  always_comb begin
    status.free_mask  = free_mask;
    status.busy_count = busy_count;
    status.idle_nbr   = idle_nbr;
    status.ctrl_idx   = CTRL_IDX;
    status.spare      = '0;
  end

endmodule

// File: map_controller.sv
// Request decode for the mapper: per-cluster set and clear strobes,
// source chain of the current application and the registered result

`include "mapper_params.svh"

module map_controller
  import mapper_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                alloc_req,
  input  logic                                release_req,
  input  pe_id_t                              release_id,
  input  logic                                app_end,
  input  cluster_t                            active_cluster,
  input  cluster_status_t [`NUM_CLUSTERS-1:0] status,
  output logic [`NUM_CLUSTERS-1:0]            set_stb,
  output local_idx_t [`NUM_CLUSTERS-1:0]      set_idx,
  output logic [`NUM_CLUSTERS-1:0]            clr_stb,
  output local_idx_t [`NUM_CLUSTERS-1:0]      clr_idx,
  output logic                                map_done,
  output map_result_t                         map_result
);

  cluster_status_t act_status;
  logic            found;
  local_idx_t      best_idx;
  logic            alloc_fire;
  cluster_t        rel_cl;
  local_idx_t      rel_idx;
  pe_id_t          ctrl_id;
  pe_id_t          src_id;
  pe_id_t          dest_id;
  pe_id_t          last_dest;
  logic            chain_valid;

  // ########################################
  // Selection in the active cluster
  // ########################################
  assign act_status = status[active_cluster];

  pe_selector u_pe_selector (
    .status   (act_status),
    .found    (found),
    .best_idx (best_idx)
  );

  assign alloc_fire = alloc_req && found;

  // Release id seen through the pos view
  assign rel_cl  = cluster_of(release_id);
  assign rel_idx = {release_id.pos.row_lo, release_id.pos.col_lo};

  always_comb begin
    for (int c = 0; c < `NUM_CLUSTERS; c++) begin
      set_stb[c] = alloc_fire && (active_cluster == cluster_t'(c));
      set_idx[c] = best_idx;
      clr_stb[c] = release_req && (rel_cl == cluster_t'(c));
      clr_idx[c] = rel_idx;
    end
  end

  // ########################################
  // Source chain and result
  // ########################################
  // First task of an application starts from the controller PE
  assign ctrl_id = id_of(active_cluster, act_status.ctrl_idx);
  assign src_id  = chain_valid ? last_dest : ctrl_id;
  assign dest_id = found ? id_of(active_cluster, best_idx) : ctrl_id;

  always_ff @(posedge clk) begin
    if (!rst_b) begin
      map_done    <= 1'b0;
      chain_valid <= 1'b0;
    end else begin
      map_done <= alloc_req;
      // app_end wins, a same-cycle alloc still used the old chain
      if (app_end) begin
        chain_valid <= 1'b0;
      end else if (alloc_fire) begin
        chain_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      last_dest <= dest_id;
    end
    if (alloc_req) begin
      map_result.ok      <= found;
      map_result.src_id  <= src_id;
      map_result.dest_id <= dest_id;
    end
  end

endmodule

// File: map_patterns.txt
# op id ok src dest, decimal global ids row*8+col; A alloc, R release id,
# AR alloc with same-cycle release of id, E app_end with dest = active cluster
A  0 1  0 10
A  0 1 10 17
A  0 1 17 18
A  0 1 18  9
A  0 1  9  3
A  0 1  3 24
A  0 1 24 27
A  0 1 27  1
A  0 1  1 11
A  0 1 11 16
A  0 1 16 26
A  0 1 26  2
A  0 1  2  8
A  0 1  8 19
A  0 1 19 25
A  0 0 25  0
R 18 0  0  0
A  0 1 25 18
R  0 0  0  0
A  0 0 18  0
AR 9 0 18  0
A  0 1 18  9
E  0 0  0  3
A  0 1 56 41
E  0 0  0  2
A  0 1 63 45
A  0 1 45 46
A  0 1 46 53
R 46 0  0  0
A  0 1 53 46
E  0 0  0  1
A  0 1  7 13

// File: mapper_params.svh
// Mesh, cluster and field sizes of the task mapper
// Shared by the package and every mapper module

`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// ########################################
// Mesh geometry
// ########################################
`define MESH_DIM      8
`define CL_DIM        4
`define NUM_CLUSTERS  4
`define PE_PER_CL     16

// ########################################
// Field widths
// ########################################
`define ID_W          6
`define LOCAL_W       4
// Busy count holds 0 to 16
`define CNT_W         5
`define NBR_W         4

// Largest Manhattan distance counted as a neighbor
`define NBR_DIST      2

`endif

// File: mapper_pkg.sv
// Types of the task mapper: PE id union, cluster and count types,
// per-cluster status word, mapping result and id conversion functions

`include "mapper_params.svh"

package mapper_pkg;

  localparam int HALF_BITS = $clog2(`MESH_DIM / `CL_DIM);
  localparam int LOC_BITS  = $clog2(`CL_DIM);

  // Global id split into mesh half and cluster-local position
  typedef struct packed {
    logic [HALF_BITS-1:0] row_hi;
    logic [LOC_BITS-1:0]  row_lo;
    logic [HALF_BITS-1:0] col_hi;
    logic [LOC_BITS-1:0]  col_lo;
  } pe_pos_t;

  // flat is row*8+col, pos is the same bits seen as cluster and local place
  typedef union packed {
    logic [`ID_W-1:0] flat;
    pe_pos_t          pos;
  } pe_id_t;

  typedef logic [$clog2(`NUM_CLUSTERS)-1:0] cluster_t;
  typedef logic [`LOCAL_W-1:0]              local_idx_t;
  typedef logic [`CNT_W-1:0]                busy_cnt_t;
  typedef logic [`NBR_W-1:0]                nbr_cnt_t;

  typedef struct packed {
    logic [`PE_PER_CL-1:0]     free_mask;
    busy_cnt_t                 busy_count;
    nbr_cnt_t [`PE_PER_CL-1:0] idle_nbr;
    local_idx_t                ctrl_idx;
    logic [11:0]               spare;
  } cluster_status_t;

  typedef struct packed {
    logic   ok;
    pe_id_t src_id;
    pe_id_t dest_id;
  } map_result_t;

  // Controller sits on the outer mesh corner of its cluster
  function automatic local_idx_t ctrl_local_of(cluster_t c);
    logic [LOC_BITS-1:0] lrow;
    logic [LOC_BITS-1:0] lcol;
    lrow = {LOC_BITS{c[1]}};
    lcol = {LOC_BITS{c[1] ^ c[0]}};
    return {lrow, lcol};
  endfunction

  // Clusters run clockwise from the top left quadrant
  function automatic cluster_t cluster_of(pe_id_t id);
    return {id.pos.row_hi, id.pos.row_hi ^ id.pos.col_hi};
  endfunction

  function automatic pe_id_t id_of(cluster_t c, local_idx_t l);
    pe_id_t id;
    id.pos.row_hi = c[1];
    id.pos.col_hi = c[1] ^ c[0];
    id.pos.row_lo = l[`LOCAL_W-1 -: LOC_BITS];
    id.pos.col_lo = l[LOC_BITS-1:0];
    return id;
  endfunction

endpackage

// File: pe_selector.sv
// Best free PE of one cluster: most idle neighbors,
// lowest local index on a tie

`include "mapper_params.svh"

module pe_selector
  import mapper_pkg::*;
(
  input  cluster_status_t status,
  output logic            found,
  output local_idx_t      best_idx
);

  nbr_cnt_t best_cnt;
  logic     any_free;
  local_idx_t pick;

  // Linear scan, strict compare keeps the first index holding the max
  always_comb begin
    any_free = 1'b0;
    pick     = '0;
    best_cnt = '0;
    for (int i = 0; i < `PE_PER_CL; i++) begin
      if (status.free_mask[i]) begin
        if (!any_free || (status.idle_nbr[i] > best_cnt)) begin
          pick     = local_idx_t'(i);
          best_cnt = status.idle_nbr[i];
        end
        any_free = 1'b1;
      end
    end
  end

  // No free PE leaves found low, best_idx is then don't care
  assign found    = any_free;
  assign best_idx = pick;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the task mapper testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f all.f --top-module tb_task_mapper -o tb_task_mapper &&
  ./obj_dir/tb_task_mapper || exit 1

// File: task_mapper.sv
// Top level of the task mapper: four cluster trackers,
// the cluster arbiter and the request controller

`include "mapper_params.svh"

module task_mapper
  import mapper_pkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  logic        alloc_req,
  input  logic        release_req,
  input  pe_id_t      release_id,
  input  logic        app_end,
  output logic        map_done,
  output map_result_t map_result,
  output cluster_t    active_cluster
);

  cluster_status_t [`NUM_CLUSTERS-1:0] status;
  busy_cnt_t [`NUM_CLUSTERS-1:0]       busy_counts;
  logic [`NUM_CLUSTERS-1:0]            set_stb;
  local_idx_t [`NUM_CLUSTERS-1:0]      set_idx;
  logic [`NUM_CLUSTERS-1:0]            clr_stb;
  local_idx_t [`NUM_CLUSTERS-1:0]      clr_idx;

  // ########################################
  // Cluster trackers
  // ########################################
  for (genvar c = 0; c < `NUM_CLUSTERS; c++) begin : g_cluster
    cluster_occupancy #(
      .CTRL_IDX (ctrl_local_of(cluster_t'(c)))
    ) u_cluster_occupancy (
      .clk     (clk),
      .rst_b   (rst_b),
      .set_stb (set_stb[c]),
      .set_idx (set_idx[c]),
      .clr_stb (clr_stb[c]),
      .clr_idx (clr_idx[c]),
      .status  (status[c])
    );

    assign busy_counts[c] = status[c].busy_count;
  end

  // ########################################
  // Cluster choice and request handling
  // ########################################
  cluster_arbiter u_cluster_arbiter (
    .clk            (clk),
    .rst_b          (rst_b),
    .app_end        (app_end),
    .busy_counts    (busy_counts),
    .active_cluster (active_cluster)
  );

  map_controller u_map_controller (
    .clk            (clk),
    .rst_b          (rst_b),
    .alloc_req      (alloc_req),
    .release_req    (release_req),
    .release_id     (release_id),
    .app_end        (app_end),
    .active_cluster (active_cluster),
    .status         (status),
    .set_stb        (set_stb),
    .set_idx        (set_idx),
    .clr_stb        (clr_stb),
    .clr_idx        (clr_idx),
    .map_done       (map_done),
    .map_result     (map_result)
  );

endmodule

// File: tb_task_mapper.sv
// Testbench for the task mapper
// Replays the operation patterns against the DUT and checks results,
// map_done latency and the active cluster after each application end

`include "mapper_params.svh"

module tb_task_mapper
  import mapper_pkg::*;
();

  localparam int    CLK_PERIOD   = 10;
  localparam int    RESET_CYCLES = 16;
  localparam int    SEED         = 803;
  localparam int    DONE_TIMEOUT = 20;
  localparam string PATTERN_FILE = "map_patterns.txt";

  // Opcodes as read by %s, right-justified ASCII
  localparam logic [15:0] OP_A  = 16'h0041;
  localparam logic [15:0] OP_R  = 16'h0052;
  localparam logic [15:0] OP_E  = 16'h0045;
  localparam logic [15:0] OP_AR = 16'h4152;

  logic        clk;
  logic        rst_b;
  logic        alloc_req;
  logic        release_req;
  pe_id_t      release_id;
  logic        app_end;
  logic        map_done;
  map_result_t map_result;
  cluster_t    active_cluster;

  task_mapper DUT (
    .clk            (clk),
    .rst_b          (rst_b),
    .alloc_req      (alloc_req),
    .release_req    (release_req),
    .release_id     (release_id),
    .app_end        (app_end),
    .map_done       (map_done),
    .map_result     (map_result),
    .active_cluster (active_cluster)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ########################################
  // Checking
  // ########################################
  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, int actual, int expected);
    if (actual != expected) begin
      fail_run($sformatf("[FAIL] t=%0t %s: got %0d, expected %0d",
                         $time, name, actual, expected));
    end
  endtask

  // Result must show up on the first falling edge after the request is taken
  task automatic wait_done();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!map_done && (cycles < DONE_TIMEOUT));
    if (!map_done) begin
      fail_run("map_done never came back after an allocation request");
    end
    check_value("map_done delay", cycles, 1);
  endtask

  // ########################################
  // Operations
  // ########################################
  task automatic insert_gap();
    int gap;
    gap = int'($urandom % 4);
    repeat (gap) begin
      @(posedge clk);
      @(negedge clk);
      check_value("map_done", int'(map_done), 0);
    end
  endtask

  task automatic request_alloc(logic with_release, int rel, int exp_ok,
                               int exp_src, int exp_dst);
    @(posedge clk);
    alloc_req       <= 1'b1;
    release_req     <= with_release;
    release_id.flat <= rel[`ID_W-1:0];
    @(posedge clk);
    alloc_req   <= 1'b0;
    release_req <= 1'b0;
    wait_done();
    check_value("map_result.ok", int'(map_result.ok), exp_ok);
    check_value("map_result.src_id", int'(map_result.src_id.flat), exp_src);
    check_value("map_result.dest_id", int'(map_result.dest_id.flat), exp_dst);
  endtask

  task automatic request_release(int rel);
    @(posedge clk);
    release_req     <= 1'b1;
    release_id.flat <= rel[`ID_W-1:0];
    @(posedge clk);
    release_req <= 1'b0;
    @(negedge clk);
    check_value("map_done", int'(map_done), 0);
  endtask

  task automatic signal_app_end(int exp_cl);
    @(posedge clk);
    app_end <= 1'b1;
    @(posedge clk);
    app_end <= 1'b0;
    @(negedge clk);
    check_value("active_cluster", int'(active_cluster), exp_cl);
  endtask

  // ########################################
  // Main sequence
  // ########################################
  initial begin
    int          fd;
    int          n_ops;
    int          fields;
    int          arg;
    int          exp_ok;
    int          exp_src;
    int          exp_dst;
    string       line;
    logic [15:0] op;
    void'($urandom(SEED));
    rst_b       <= 1'b0;
    alloc_req   <= 1'b0;
    release_req <= 1'b0;
    release_id  <= '0;
    app_end     <= 1'b0;
    n_ops = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    check_value("active_cluster", int'(active_cluster), 0);
    check_value("map_done", int'(map_done), 0);

    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      fail_run("could not open the pattern file");
    end

    while ($fgets(line, fd) > 0) begin
      // Skip blank lines and column notes
      if ((line.len() > 1) && (line.getc(0) != "#")) begin
        op = '0;
        fields = $sscanf(line, "%s %d %d %d %d", op, arg, exp_ok, exp_src, exp_dst);
        if (fields != 5) begin
          fail_run("a pattern line does not hold five fields");
        end
        insert_gap();
        case (op)
          OP_A:    request_alloc(1'b0, 0, exp_ok, exp_src, exp_dst);
          OP_AR:   request_alloc(1'b1, arg, exp_ok, exp_src, exp_dst);
          OP_R:    request_release(arg);
          OP_E:    signal_app_end(exp_dst);
          default: fail_run("a pattern line holds an unknown opcode");
        endcase
        n_ops++;
      end
    end
    $fclose(fd);

    if (n_ops == 0) begin
      fail_run("the pattern file held no operations");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule
